// ==== xv_video_pkg.sv ====
// ====================
// video side definitions
// raster is a tiny fixed test mode, not a real monitor timing
// colour is direct 12-bit rgb, no palette
// ====================

package xv_video_pkg;

    typedef logic [9:0]  addr_t;        // vram word address
    typedef logic [15:0] word_t;        // vram data word
    typedef logic [3:0]  rgb_t;         // one colour gun
    typedef logic [4:0]  hcount_t;      // horizontal pixel counter
    typedef logic [3:0]  vcount_t;      // vertical line counter

    // horizontal timing, in pixel clocks
    localparam hcount_t H_VIS        = 5'd16;
    localparam hcount_t H_TOTAL      = 5'd24;
    localparam hcount_t H_SYNC_START = 5'd18;
    localparam hcount_t H_SYNC_LEN   = 5'd2;

    // vertical timing, in lines
    localparam vcount_t V_VIS        = 4'd6;
    localparam vcount_t V_TOTAL      = 4'd10;
    localparam vcount_t V_SYNC_START = 4'd7;
    localparam vcount_t V_SYNC_LEN   = 4'd1;

    localparam int FETCH_LAT  = 2;      // fetch address to colour out
    localparam int VRAM_WORDS = 1024;   // matches addr_t

endpackage

// ==== xv_bus_pkg.sv ====
// ====================
// host bus side definitions
// registers are 16 bits, reached one byte at a time
// interrupt bit order is fixed, video high, timer low
// ====================

package xv_bus_pkg;

    typedef logic [3:0] regnum_t;       // register number on the bus
    typedef logic [7:0] byte_t;         // one bus byte
    typedef logic [1:0] intr_t;         // interrupt bit vector

    // interrupt bit positions
    localparam int INTR_VIDEO = 1;      // start of vertical blank
    localparam int INTR_TIMER = 0;      // timer compare match

    // register map
    localparam regnum_t REG_WR_ADDR    = 4'h0;  // vram write address
    localparam regnum_t REG_RD_ADDR    = 4'h1;  // vram read address, write starts read
    localparam regnum_t REG_DATA       = 4'h2;  // vram data port
    localparam regnum_t REG_INT_CTRL   = 4'h3;  // mask high byte, pending low byte
    localparam regnum_t REG_DISP_START = 4'h4;  // first word shown each frame
    localparam regnum_t REG_STATUS     = 4'h5;  // busy and blank flags
    localparam regnum_t REG_TIMER_CMP  = 4'h6;  // timer compare value

    localparam int TIMER_DIV = 4;       // clocks per timer tick

endpackage

// ==== vram_arb.sv ====
// ====================
// single port vram with two requesters
// video port always wins, no ack, data valid next cycle
// register port waits for a video-free cycle, one cycle ack after
// contents are not cleared by reset
// ====================

`default_nettype none

module vram_arb(
    input  wire logic                   clk,
    input  wire logic                   vgen_sel_i,     // video fetch this cycle
    input  wire xv_video_pkg::addr_t    vgen_addr_i,
    input  wire logic                   regs_sel_i,     // held until ack
    input  wire logic                   regs_wr_i,      // 1 = write, 0 = read
    input  wire xv_video_pkg::addr_t    regs_addr_i,
    input  wire xv_video_pkg::word_t    regs_wdata_i,
    output logic                        regs_ack_o,     // one cycle, after access
    output xv_video_pkg::word_t         vram_data_o     // shared by both ports
);

    import xv_video_pkg::*;

    word_t  vram [VRAM_WORDS];      // the video memory itself
    logic   regs_go;                // register port gets this cycle
    addr_t  mem_addr;

    // skip the ack cycle, sel is still high there
    assign regs_go  = regs_sel_i & ~vgen_sel_i & ~regs_ack_o;
    assign mem_addr = vgen_sel_i ? vgen_addr_i : regs_addr_i;

    always_ff @(posedge clk) begin
        if (regs_go && regs_wr_i) begin
            vram[mem_addr] <= regs_wdata_i;
        end else begin
            vram_data_o <= vram[mem_addr];  // video or register read
        end
        regs_ack_o <= regs_go;
    end

endmodule

`default_nettype wire

// ==== video_gen.sv ====
// ====================
// fixed raster generator with one vram fetch per visible pixel
// syncs are active high, all outputs delayed by FETCH_LAT
// disp_start is taken during vertical blank only
// colour is forced to zero outside display enable
// ====================

`default_nettype none

module video_gen(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire xv_video_pkg::addr_t    disp_start_i,   // first word of frame
    input  wire xv_video_pkg::word_t    vram_data_i,    // fetched pixel, next cycle
    output logic                        vram_sel_o,
    output xv_video_pkg::addr_t         vram_addr_o,
    output xv_video_pkg::rgb_t          red_o,
    output xv_video_pkg::rgb_t          green_o,
    output xv_video_pkg::rgb_t          blue_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o,
    output logic                        h_blank_o,      // undelayed, for status
    output logic                        v_blank_o,
    output logic                        video_intr_o    // pulse at v_blank rise
);

    import xv_video_pkg::*;

    hcount_t                h_count;
    vcount_t                v_count;
    logic                   h_last;
    logic                   v_last;
    logic                   visible;
    logic                   hsync;
    logic                   vsync;
    logic                   v_blank_q;      // for the rising edge
    addr_t                  fetch_addr;
    logic [FETCH_LAT-1:0]   hs_dl;          // sync and enable delay lines
    logic [FETCH_LAT-1:0]   vs_dl;
    logic [FETCH_LAT-1:0]   de_dl;
    logic [11:0]            color_q;        // r g b nibbles

    assign h_last    = (h_count == hcount_t'(H_TOTAL - 1));
    assign v_last    = (v_count == vcount_t'(V_TOTAL - 1));
    assign h_blank_o = (h_count >= H_VIS);
    assign v_blank_o = (v_count >= V_VIS);
    assign visible   = ~h_blank_o & ~v_blank_o;

    assign hsync = (h_count >= H_SYNC_START) && (h_count < H_SYNC_START + H_SYNC_LEN);
    assign vsync = (v_count >= V_SYNC_START) && (v_count < V_SYNC_START + V_SYNC_LEN);

    // fetch request goes out in the pixel's own cycle
    assign vram_sel_o   = visible;
    assign vram_addr_o  = fetch_addr;
    assign video_intr_o = v_blank_o & ~v_blank_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count    <= '0;
            v_count    <= '0;
            v_blank_q  <= 1'b0;
            fetch_addr <= '0;
            hs_dl      <= '0;
            vs_dl      <= '0;
            de_dl      <= '0;
        end else begin
            if (h_last) begin
                h_count <= '0;
                v_count <= v_last ? '0 : v_count + 1'b1;    // end of line
            end else begin
                h_count <= h_count + 1'b1;
            end
            v_blank_q <= v_blank_o;

            // reload during blank so the frame starts at disp_start
            if (v_blank_o) begin
                fetch_addr <= disp_start_i;
            end else if (visible) begin
                fetch_addr <= fetch_addr + 1'b1;    // wraps at VRAM_WORDS
            end

            hs_dl <= {hs_dl[FETCH_LAT-2:0], hsync};
            vs_dl <= {vs_dl[FETCH_LAT-2:0], vsync};
            de_dl <= {de_dl[FETCH_LAT-2:0], visible};
        end
    end

    // data of the fetch arrives one cycle later, register it once more
    always_ff @(posedge clk) begin
        color_q <= de_dl[FETCH_LAT-2] ? vram_data_i[11:0] : 12'h000;
    end

    assign red_o   = color_q[11:8];
    assign green_o = color_q[7:4];
    assign blue_o  = color_q[3:0];
    assign hsync_o = hs_dl[FETCH_LAT-1];
    assign vsync_o = vs_dl[FETCH_LAT-1];
    assign dv_de_o = de_dl[FETCH_LAT-1];

endmodule

`default_nettype wire

// ==== bus_regs.sv ====
// ====================
// host register interface, byte wide
// bus inputs must be stable while chip select is low
// one vram request at a time, poll REG_STATUS bit 0 first
// commands arriving while busy are dropped
// writing REG_TIMER_CMP restarts the timer count
// ====================

`default_nettype none

module bus_regs(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_cs_n_i,     // active low select
    input  wire logic                   bus_rd_nwr_i,   // 1 = read, 0 = write
    input  wire xv_bus_pkg::regnum_t    bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,  // 0 = even (high) byte
    input  wire xv_bus_pkg::byte_t      bus_data_i,
    input  wire logic                   regs_ack_i,
    input  wire xv_video_pkg::word_t    vram_data_i,
    input  wire logic                   h_blank_i,
    input  wire logic                   v_blank_i,
    input  wire logic                   video_intr_i,
    output xv_bus_pkg::byte_t           bus_data_o,
    output logic                        regs_sel_o,
    output logic                        regs_wr_o,
    output xv_video_pkg::addr_t         regs_addr_o,
    output xv_video_pkg::word_t         regs_wdata_o,
    output xv_video_pkg::addr_t         disp_start_o,
    output logic                        bus_intr_o
);

    import xv_bus_pkg::*;
    import xv_video_pkg::*;

    logic                           cs_meta;        // two stage sync
    logic                           cs_sync;
    logic                           cs_prev;        // for falling edge
    logic                           cs_strobe;
    logic                           wr_commit;      // odd byte write
    word_t                          wr_word;
    word_t                          reg_rd_val;
    byte_t                          hold_q;         // even byte latch
    byte_t                          rd_byte_q;
    word_t                          rd_word_q;      // last vram read
    addr_t                          wr_addr_q;
    addr_t                          rd_addr_q;
    word_t                          timer_cmp_q;
    word_t                          timer_cnt;
    logic [$clog2(TIMER_DIV)-1:0]   timer_div;
    logic                           tick;
    logic                           timer_hit;
    intr_t                          intr_src;
    intr_t                          intr_mask;
    intr_t                          intr_pend;
    intr_t                          intr_clear;

    assign cs_strobe = cs_prev & ~cs_sync;
    assign wr_commit = cs_strobe & ~bus_rd_nwr_i & bus_bytesel_i;
    assign wr_word   = {hold_q, bus_data_i};

    assign tick      = (timer_div == ($clog2(TIMER_DIV))'(TIMER_DIV - 1));
    assign timer_hit = tick && (timer_cnt == timer_cmp_q) && (timer_cmp_q != '0);

    always_comb begin
        intr_src             = '0;
        intr_src[INTR_VIDEO] = video_intr_i;
        intr_src[INTR_TIMER] = timer_hit;
        intr_clear = (wr_commit && bus_reg_num_i == REG_INT_CTRL) ? intr_t'(bus_data_i) : '0;
    end

    // register read mux
    always_comb begin
        case (bus_reg_num_i)
            REG_WR_ADDR:    reg_rd_val = word_t'(wr_addr_q);
            REG_RD_ADDR:    reg_rd_val = word_t'(rd_addr_q);
            REG_DATA:       reg_rd_val = rd_word_q;
            REG_INT_CTRL:   reg_rd_val = {6'b0, intr_mask, 6'b0, intr_pend};
            REG_DISP_START: reg_rd_val = word_t'(disp_start_o);
            REG_STATUS:     reg_rd_val = {13'b0, v_blank_i, h_blank_i, regs_sel_o};
            REG_TIMER_CMP:  reg_rd_val = timer_cmp_q;
            default:        reg_rd_val = '0;
        endcase
    end

    assign regs_addr_o = regs_wr_o ? wr_addr_q : rd_addr_q;
    assign bus_data_o  = rd_byte_q;     // holds until the next read

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_meta <= 1'b1;
            cs_sync <= 1'b1;
            cs_prev <= 1'b1;
        end else begin
            cs_meta <= bus_cs_n_i;
            cs_sync <= cs_meta;
            cs_prev <= cs_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs_sel_o   <= 1'b0;
            regs_wr_o    <= 1'b0;
            wr_addr_q    <= '0;
            rd_addr_q    <= '0;
            disp_start_o <= '0;
            timer_cmp_q  <= '0;
            timer_cnt    <= '0;
            timer_div    <= '0;
            intr_mask    <= '0;
            intr_pend    <= '0;
            bus_intr_o   <= 1'b0;
        end else begin
            timer_div <= timer_div + 1'b1;
            if (tick) begin
                timer_cnt <= timer_cnt + 1'b1;
            end

            if (regs_ack_i) begin
                regs_sel_o <= 1'b0;             // request done
                if (regs_wr_o) begin
                    wr_addr_q <= wr_addr_q + 1'b1;
                end
            end

            if (wr_commit) begin
                case (bus_reg_num_i)
                    REG_WR_ADDR: begin
                        if (!regs_sel_o) wr_addr_q <= addr_t'(wr_word);
                    end
                    REG_RD_ADDR: begin
                        if (!regs_sel_o) begin
                            rd_addr_q  <= addr_t'(wr_word);
                            regs_sel_o <= 1'b1;
                            regs_wr_o  <= 1'b0;
                        end
                    end
                    REG_DATA: begin
                        if (!regs_sel_o) begin
                            regs_sel_o <= 1'b1;
                            regs_wr_o  <= 1'b1;
                        end
                    end
                    REG_INT_CTRL:   intr_mask    <= intr_t'(hold_q);
                    REG_DISP_START: disp_start_o <= addr_t'(wr_word);
                    REG_TIMER_CMP: begin
                        timer_cmp_q <= wr_word;
                        timer_cnt   <= '0;      // count again from zero
                        timer_div   <= '0;
                    end
                    default: ;
                endcase
            end

            // new, enabled and not yet pending
            bus_intr_o <= |(intr_src & intr_mask & ~intr_pend);
            intr_pend  <= (intr_pend | intr_src) & ~intr_clear;
        end
    end

    // data path latches
    always_ff @(posedge clk) begin
        if (cs_strobe && !bus_rd_nwr_i && !bus_bytesel_i) begin
            hold_q <= bus_data_i;
        end
        if (cs_strobe && bus_rd_nwr_i) begin
            rd_byte_q <= bus_bytesel_i ? reg_rd_val[7:0] : reg_rd_val[15:8];
        end
        if (wr_commit && bus_reg_num_i == REG_DATA && !regs_sel_o) begin
            regs_wdata_o <= wr_word;
        end
        if (regs_ack_i && !regs_wr_o) begin
            rd_word_q <= vram_data_i;   // valid in the ack cycle
        end
    end

endmodule

`default_nettype wire

// ==== xosera_main.sv ====
// ====================
// top level of the cut down video controller
// host bus in, rgb444 video and interrupt out
// single clock domain apart from the bus select sync
// ====================

`default_nettype none

module xosera_main(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_cs_n_i,
    input  wire logic                   bus_rd_nwr_i,
    input  wire xv_bus_pkg::regnum_t    bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,
    input  wire xv_bus_pkg::byte_t      bus_data_i,
    output xv_bus_pkg::byte_t           bus_data_o,
    output logic                        bus_intr_o,
    output xv_video_pkg::rgb_t          red_o,
    output xv_video_pkg::rgb_t          green_o,
    output xv_video_pkg::rgb_t          blue_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);

    import xv_video_pkg::*;

    logic   vgen_sel;           // video fetch request
    addr_t  vgen_addr;
    logic   regs_sel;           // register vram request
    logic   regs_wr;
    addr_t  regs_addr;
    word_t  regs_wdata;
    logic   regs_ack;
    word_t  vram_data;          // shared read data
    addr_t  disp_start;
    logic   h_blank;
    logic   v_blank;
    logic   video_intr;

    bus_regs bus_regs(
        .clk(clk),
        .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i),
        .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i),
        .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i),
        .regs_ack_i(regs_ack),
        .vram_data_i(vram_data),
        .h_blank_i(h_blank),
        .v_blank_i(v_blank),
        .video_intr_i(video_intr),
        .bus_data_o(bus_data_o),
        .regs_sel_o(regs_sel),
        .regs_wr_o(regs_wr),
        .regs_addr_o(regs_addr),
        .regs_wdata_o(regs_wdata),
        .disp_start_o(disp_start),
        .bus_intr_o(bus_intr_o)
    );

    video_gen video_gen(
        .clk(clk),
        .reset_i(reset_i),
        .disp_start_i(disp_start),
        .vram_data_i(vram_data),
        .vram_sel_o(vgen_sel),
        .vram_addr_o(vgen_addr),
        .red_o(red_o),
        .green_o(green_o),
        .blue_o(blue_o),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o),
        .dv_de_o(dv_de_o),
        .h_blank_o(h_blank),
        .v_blank_o(v_blank),
        .video_intr_o(video_intr)
    );

    vram_arb vram_arb(
        .clk(clk),
        .vgen_sel_i(vgen_sel),
        .vgen_addr_i(vgen_addr),
        .regs_sel_i(regs_sel),
        .regs_wr_i(regs_wr),
        .regs_addr_i(regs_addr),
        .regs_wdata_i(regs_wdata),
        .regs_ack_o(regs_ack),
        .vram_data_o(vram_data)
    );

endmodule

`default_nettype wire

// ==== xosera_sva.sv ====
// ====================
// assertions bound into the top level
// mask and sources are taken from inside the register block
// checks are off while reset is high
// ====================

module xosera_sva(
    input wire logic                clk,
    input wire logic                reset_i,
    input wire logic                vgen_sel_i,     // video fetch request
    input wire logic                regs_ack_i,
    input wire logic                bus_intr_i,
    input wire xv_bus_pkg::intr_t   intr_src_i,
    input wire xv_bus_pkg::intr_t   intr_mask_i
);

    // ack is one clock wide
    ack_single: assert property (@(posedge clk) disable iff (reset_i)
        regs_ack_i |=> !regs_ack_i)
        else $error("regs_ack high in two consecutive clocks");

    // access only in a clock without video fetch
    ack_after_free: assert property (@(posedge clk) disable iff (reset_i)
        regs_ack_i |-> !$past(vgen_sel_i))
        else $error("regs_ack after a clock with vgen_sel high");

    intr_masked: assert property (@(posedge clk) disable iff (reset_i)
        $rose(bus_intr_i) |-> $past(|(intr_src_i & intr_mask_i)))
        else $error("bus_intr_o rose for a masked source");

endmodule

bind xosera_main xosera_sva xosera_sva0(
    .clk(clk),
    .reset_i(reset_i),
    .vgen_sel_i(vgen_sel),
    .regs_ack_i(regs_ack),
    .bus_intr_i(bus_intr_o),
    .intr_src_i(bus_regs.intr_src),
    .intr_mask_i(bus_regs.intr_mask)
);

// ==== tb_xosera.sv ====
// ====================
// testbench for the cut down video controller
// bus cycles hold chip select low 6 clocks and high 4
// vram is only compared where the test wrote it
// the first failed check ends the run
// ====================

module tb_xosera;

    import xv_bus_pkg::*;
    import xv_video_pkg::*;

    localparam int BLOCK_WORDS  = 128;      // words written then read back
    localparam int POLL_LIMIT   = 40;       // status polls before giving up
    localparam int WAIT_LIMIT   = 2000;     // clocks for any other wait
    localparam int FRAME_PIXELS = int'(H_VIS) * int'(V_VIS);
    localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int SYNC_CYCLES  = int'(V_SYNC_LEN) * int'(H_TOTAL);

    logic       clk;
    logic       reset_i;
    logic       bus_cs_n;
    logic       bus_rd_nwr;
    regnum_t    bus_reg_num;
    logic       bus_bytesel;
    byte_t      bus_data_in;
    byte_t      bus_data_out;
    logic       bus_intr;
    rgb_t       red;
    rgb_t       green;
    rgb_t       blue;
    logic       hsync;
    logic       vsync;
    logic       dv_de;

    word_t      shadow [VRAM_WORDS];        // expected vram contents
    addr_t      disp_start_sh;
    logic       video_check_en;
    logic       in_frame;
    logic       vs_prev;
    logic       hs_prev;
    int         frames_done;
    int         pix_n;                      // visible pixel index in frame
    int         hs_rises;
    int         vs_cycles;
    int         frame_cycles;
    logic       intr_prev;
    int         intr_pulses;
    int         cycle_no;
    int         last_rise;
    int         intr_gap;                   // clocks between last two pulses

    xosera_main dut0(
        .clk(clk),
        .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n),
        .bus_rd_nwr_i(bus_rd_nwr),
        .bus_reg_num_i(bus_reg_num),
        .bus_bytesel_i(bus_bytesel),
        .bus_data_i(bus_data_in),
        .bus_data_o(bus_data_out),
        .bus_intr_o(bus_intr),
        .red_o(red),
        .green_o(green),
        .blue_o(blue),
        .hsync_o(hsync),
        .vsync_o(vsync),
        .dv_de_o(dv_de)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "testbench stopped at the first failure");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            stop_on_failure($sformatf("Error: %s expected 0x%0h actual 0x%0h",
                                      name, expected, actual));
        end
    endtask

    // pixel n of a frame shows word disp_start + n, low 12 bits
    function automatic int expected_pixel(input int n);
        addr_t a;
        a = addr_t'((int'(disp_start_sh) + n) % VRAM_WORDS);
        return int'(shadow[a][11:0]);
    endfunction

    // one byte cycle, starts and ends on a falling edge
    task automatic bus_cycle(input logic rd, input regnum_t num, input logic bsel,
                             input byte_t din, output byte_t dout);
        bus_cs_n    = 1'b0;
        bus_rd_nwr  = rd;
        bus_reg_num = num;
        bus_bytesel = bsel;
        bus_data_in = din;
        repeat (6) @(negedge clk);
        dout     = bus_data_out;        // read byte valid by now
        bus_cs_n = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    task automatic write_reg(input regnum_t num, input word_t val);
        byte_t ignored;
        bus_cycle(1'b0, num, 1'b0, val[15:8], ignored);     // even byte latched
        bus_cycle(1'b0, num, 1'b1, val[7:0], ignored);      // odd byte commits
    endtask

    task automatic read_reg(input regnum_t num, output word_t val);
        byte_t hi;
        byte_t lo;
        bus_cycle(1'b1, num, 1'b0, 8'h00, hi);
        bus_cycle(1'b1, num, 1'b1, 8'h00, lo);
        val = {hi, lo};
    endtask

    // REG_STATUS bit 0 is the pending vram request
    task automatic wait_vram_idle();
        byte_t status;
        int    polls;
        status = 8'h01;
        polls  = 0;
        while (status[0]) begin
            if (polls >= POLL_LIMIT) begin
                stop_on_failure("vram request still pending after polling REG_STATUS");
            end else begin
                bus_cycle(1'b1, REG_STATUS, 1'b1, 8'h00, status);
                polls++;
            end
        end
    endtask

    task automatic wait_intr_pulse(input int start_count);
        int cycles;
        cycles = 0;
        while (intr_pulses == start_count) begin
            if (cycles >= WAIT_LIMIT) begin
                stop_on_failure("bus_intr_o did not pulse in time");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // interrupt pulse counter, pulses must be one clock wide
    always @(negedge clk) begin
        if (reset_i) begin
            intr_prev   <= 1'b0;
            intr_pulses <= 0;
            cycle_no    <= 0;
            last_rise   <= 0;
            intr_gap    <= 0;
        end else begin
            cycle_no <= cycle_no + 1;
            if (bus_intr && !intr_prev) begin
                intr_pulses <= intr_pulses + 1;
                intr_gap    <= cycle_no - last_rise;
                last_rise   <= cycle_no;
            end
            if (bus_intr && intr_prev) begin
                stop_on_failure("bus_intr_o stayed high for more than one clock");
            end
            intr_prev <= bus_intr;
        end
    end

    // video compare, a frame runs from one vsync rise to the next
    always @(negedge clk) begin
        if (reset_i || !video_check_en) begin
            in_frame    <= 1'b0;
            frames_done <= 0;
        end else if (vsync && !vs_prev) begin
            if (in_frame) begin
                check_value("hsync pulses per frame", int'(V_TOTAL), hs_rises);
                check_value("vsync clocks per frame", SYNC_CYCLES, vs_cycles);
                check_value("dv_de clocks per frame", FRAME_PIXELS, pix_n);
                check_value("clocks per frame", FRAME_CYCLES, frame_cycles);
                frames_done <= frames_done + 1;
            end
            in_frame     <= 1'b1;
            pix_n        <= 0;
            hs_rises     <= 0;
            vs_cycles    <= 1;      // this clock already has vsync
            frame_cycles <= 1;
        end else if (in_frame) begin
            if (dv_de) begin
                check_value($sformatf("pixel %0d colour", pix_n),
                            expected_pixel(pix_n), int'({red, green, blue}));
                pix_n <= pix_n + 1;
            end else begin
                check_value("colour outside dv_de", 0, int'({red, green, blue}));
            end
            if (hsync && !hs_prev) begin
                hs_rises <= hs_rises + 1;
            end
            if (vsync) begin
                vs_cycles <= vs_cycles + 1;
            end
            frame_cycles <= frame_cycles + 1;
        end
        vs_prev <= vsync;
        hs_prev <= hsync;
    end

    initial begin
        word_t rd;
        word_t wdata;
        addr_t base;
        addr_t a;
        int    start;
        int    cycles;
        int    polls;
        void'($urandom(32'h7895d2e0));
        reset_i        = 1'b1;
        bus_cs_n       = 1'b1;
        bus_rd_nwr     = 1'b1;
        bus_reg_num    = REG_STATUS;
        bus_bytesel    = 1'b0;
        bus_data_in    = 8'h00;
        video_check_en = 1'b0;
        disp_start_sh  = '0;
        repeat (3) @(negedge clk);
        reset_i = 1'b0;

        // block crosses the top of vram so addresses wrap
        base = addr_t'($urandom_range(1000, 960));
        write_reg(REG_WR_ADDR, word_t'(base));
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            wdata = word_t'($urandom);
            shadow[addr_t'(int'(base) + i)] = wdata;
            wait_vram_idle();
            write_reg(REG_DATA, wdata);
        end
        wait_vram_idle();
        read_reg(REG_WR_ADDR, rd);
        check_value("write address after auto-increment",
                    int'(addr_t'(int'(base) + BLOCK_WORDS)), int'(rd));
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            a = addr_t'(int'(base) + i);
            write_reg(REG_RD_ADDR, word_t'(a));
            wait_vram_idle();
            read_reg(REG_DATA, rd);
            check_value($sformatf("vram readback at 0x%0h", a), int'(shadow[a]), int'(rd));
        end

        // two frames of pixels from a random start
        disp_start_sh = addr_t'(int'(base) + int'($urandom_range(31, 0)));
        write_reg(REG_DISP_START, word_t'(disp_start_sh));
        video_check_en = 1'b1;
        cycles = 0;
        while (frames_done < 2) begin
            if (cycles >= WAIT_LIMIT) begin
                stop_on_failure("two complete video frames were not seen in time");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        video_check_en = 1'b0;

        // video interrupt masked in, cleared after each frame
        write_reg(REG_INT_CTRL, 16'h0203);
        for (int f = 0; f < 2; f++) begin
            start = intr_pulses;
            wait_intr_pulse(start);
            if (f == 1) begin
                check_value("clocks between video interrupts", FRAME_CYCLES, intr_gap);
            end
            read_reg(REG_INT_CTRL, rd);
            check_value("video pending with mask", 32'h0202, int'(rd));
            write_reg(REG_INT_CTRL, 16'h0202);
            read_reg(REG_INT_CTRL, rd);
            check_value("video pending cleared", 32'h0200, int'(rd));
        end

        // mask off, pending still collects
        write_reg(REG_INT_CTRL, 16'h0003);
        start = intr_pulses;
        rd    = '0;
        polls = 0;
        while (!rd[INTR_VIDEO]) begin
            if (polls >= POLL_LIMIT) begin
                stop_on_failure("video pending bit never set with the mask at zero");
            end else begin
                read_reg(REG_INT_CTRL, rd);
                polls++;
            end
        end
        check_value("video pending without mask", 32'h0002, int'(rd));
        check_value("interrupt pulses while masked", start, intr_pulses);

        // timer compare, only the timer bit masked in
        write_reg(REG_INT_CTRL, 16'h0103);
        start = intr_pulses;
        write_reg(REG_TIMER_CMP, word_t'($urandom_range(40, 3)));
        wait_intr_pulse(start);
        read_reg(REG_INT_CTRL, rd);
        check_value("timer pending with mask", 32'h0101, int'(rd & 16'hff01));

        $display("sim passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
xv_video_pkg.sv
xv_bus_pkg.sv
vram_arb.sv
video_gen.sv
bus_regs.sv
xosera_main.sv
xosera_sva.sv
tb_xosera.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with verilator
# exit status of the simulation is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_xosera -f filelist.f
./obj_dir/Vtb_xosera
